// File: lsu_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lsu_pkg
// shared widths, memory operation codes and L1.5 message codes for the
// memory-access stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package lsu_pkg;

    localparam int xlen = 32;             // data and address width

    // mem_op[3]   store = 1, load = 0
    // mem_op[2:1] word = 11, half = 01, byte = 10
    // mem_op[0]   signed = 1
    typedef logic [3:0] mem_op_t;

    localparam mem_op_t op_none = 4'b0000;
    localparam mem_op_t op_sw   = 4'b1111;
    localparam mem_op_t op_sh   = 4'b1011;
    localparam mem_op_t op_sb   = 4'b1101;
    localparam mem_op_t op_lw   = 4'b0111;
    localparam mem_op_t op_lh   = 4'b0011;
    localparam mem_op_t op_lhu  = 4'b0010;
    localparam mem_op_t op_lb   = 4'b0101;
    localparam mem_op_t op_lbu  = 4'b0100;

    // request types on the cache port
    localparam logic [3:0] rq_load  = 4'b0000;
    localparam logic [3:0] rq_store = 4'b0001;

    // return types on the response port
    localparam logic [3:0] ret_load   = 4'b0000;
    localparam logic [3:0] ret_st_ack = 4'b0100;

    // message data size
    typedef logic [2:0] msg_size_t;

    localparam msg_size_t size_1b = 3'b001;
    localparam msg_size_t size_2b = 3'b010;
    localparam msg_size_t size_4b = 3'b011;

    // one half of the 128-bit return line
    typedef logic [63:0] line_word_t;

endpackage

// File: lsu_req_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lsu_req_if
// one decoded memory access, from the decoder to the cache controller
// and the data formatters
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

interface lsu_req_if;

    logic                       valid;      // access sits in stage 6
    lsu_pkg::mem_op_t           mem_op;
    logic [lsu_pkg::xlen-1:0]   addr;       // effective address
    logic [lsu_pkg::xlen-1:0]   wdata;      // store data, little-endian
    logic [3:0]                 bw;         // byte enables, bit 0 = offset 0
    logic                       rd;         // aligned load
    logic                       misaligned;

    modport decode (output valid, mem_op, addr, wdata, bw, rd, misaligned);
    modport ctrl   (input  valid, mem_op, addr, wdata, bw, rd, misaligned);

endinterface

// File: mem_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mem_decode
// stage 5/6 decode of a load or store: effective address, misalignment
// check and byte enables, registered into the access interface
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module mem_decode (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic                        strobe,
    input  lsu_pkg::mem_op_t            mem_op,
    input  logic [lsu_pkg::xlen-1:0]    op_a,       // base address
    input  logic [lsu_pkg::xlen-1:0]    op_b,       // store data or load offset
    input  logic [lsu_pkg::xlen-1:0]    s_imm,      // store offset
    lsu_req_if.decode                   acc
);

    logic                       valid5;
    lsu_pkg::mem_op_t           mem_op5;
    logic [lsu_pkg::xlen-1:0]   op_a5;
    logic [lsu_pkg::xlen-1:0]   op_b5;
    logic [lsu_pkg::xlen-1:0]   s_imm5;

    logic [lsu_pkg::xlen-1:0]   addr5;
    logic                       store5;
    logic                       mis5;
    logic                       rd5;
    logic [3:0]                 bw5;

    // stage 5, operands held until the next strobe
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid5  <= 1'b0;
            mem_op5 <= lsu_pkg::op_none;
        end else begin
            valid5 <= strobe;
            if (strobe)
                mem_op5 <= mem_op;
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            op_a5  <= op_a;
            op_b5  <= op_b;
            s_imm5 <= s_imm;
        end
    end

    assign store5 = mem_op5[3];
    assign addr5  = store5 ? (op_a5 + s_imm5) : (op_a5 + op_b5);

    // halfword needs bit 0 clear, word needs bits 1:0 clear
    assign mis5 = (mem_op5[1] & addr5[0]) | (mem_op5[2] & mem_op5[1] & addr5[1]);
    assign rd5  = (|mem_op5) & ~store5 & ~mis5;

    always_comb begin
        bw5 = 4'b0000;
        if (store5 && !mis5) begin
            case (mem_op5[2:1])
                2'b11:   bw5 = 4'b1111;
                2'b01:   bw5 = addr5[1] ? 4'b1100 : 4'b0011;
                2'b10:   bw5 = 4'b0001 << addr5[1:0];
                default: bw5 = 4'b0000;
            endcase
        end
    end

    // stage 6
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            acc.valid      <= 1'b0;
            acc.mem_op     <= lsu_pkg::op_none;
            acc.bw         <= 4'b0000;
            acc.rd         <= 1'b0;
            acc.misaligned <= 1'b0;
        end else begin
            acc.valid <= valid5;
            if (valid5) begin
                acc.mem_op     <= mem_op5;
                acc.bw         <= bw5;
                acc.rd         <= rd5;
                acc.misaligned <= mis5;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid5) begin
            acc.addr  <= addr5;
            acc.wdata <= op_b5;     // store source is op_b
        end
    end

endmodule

// File: store_fmt.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store_fmt
// big-endian store data and message size for the cache request
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module store_fmt (
    lsu_req_if.ctrl                     acc,
    output logic [lsu_pkg::xlen-1:0]    data,
    output lsu_pkg::msg_size_t          size
);

    // cache side is big-endian
    assign data = {acc.wdata[7:0], acc.wdata[15:8], acc.wdata[23:16], acc.wdata[31:24]};

    always_comb begin
        if (acc.rd) begin
            size = lsu_pkg::size_4b;                // loads always fetch a word
        end else begin
            case (acc.bw)
                4'b1111:
                    size = lsu_pkg::size_4b;
                4'b0011, 4'b1100:
                    size = lsu_pkg::size_2b;
                4'b0001, 4'b0010, 4'b0100, 4'b1000:
                    size = lsu_pkg::size_1b;
                default:
                    size = lsu_pkg::size_4b;        // no request goes out
            endcase
        end
    end

endmodule

// File: load_align.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load_align
// picks the addressed word from the 128-bit return line, converts it to
// little-endian and extends the loaded byte or halfword
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module load_align (
    lsu_req_if.ctrl                     acc,
    input  lsu_pkg::line_word_t         data_0,
    input  lsu_pkg::line_word_t         data_1,
    output logic [lsu_pkg::xlen-1:0]    load_data
);

    logic [31:0] word_be;
    logic [31:0] word;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        sext;

    // lowest address sits in the upper half of each 64-bit word
    always_comb begin
        case (acc.addr[3:2])
            2'b00:   word_be = data_0[63:32];
            2'b01:   word_be = data_0[31:0];
            2'b10:   word_be = data_1[63:32];
            default: word_be = data_1[31:0];
        endcase
    end

    assign word     = {word_be[7:0], word_be[15:8], word_be[23:16], word_be[31:24]};
    assign byte_sel = word[{acc.addr[1:0], 3'b000} +: 8];
    assign half_sel = acc.addr[1] ? word[31:16] : word[15:0];
    assign sext     = acc.mem_op[0];

    always_comb begin
        case (acc.mem_op[2:1])
            2'b10:   load_data = {{24{sext & byte_sel[7]}}, byte_sel};   // lb, lbu
            2'b01:   load_data = {{16{sext & half_sel[15]}}, half_sel};  // lh, lhu
            default: load_data = word;
        endcase
    end

endmodule

// File: l15_req_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// l15_req_ctrl
// request/response FSM on the L1.5 cache port, one access in flight,
// plus the completion, busy and misalignment flags for the core
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module l15_req_ctrl (
    input  logic        clk,
    input  logic        nrst,
    input  logic        strobe,
    lsu_req_if.ctrl     acc,
    input  logic        header_ack,
    input  logic        resp_val,
    input  logic [3:0]  returntype,
    output logic [3:0]  rqtype,
    output logic        l15_val,
    output logic        req_ack,
    output logic        done,
    output logic        busy,
    output logic        ld_misaligned,
    output logic        st_misaligned
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_decode,
        st_request,
        st_response
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   hdr_seen_q;
    logic   issue;
    logic   mis_done;
    logic   ret_match;
    logic   resp_fire;

    assign rqtype = acc.mem_op[3] ? lsu_pkg::rq_store : lsu_pkg::rq_load;

    // request goes out the same cycle the access reaches stage 6
    assign issue   = (state_q == st_request) ||
                     (state_q == st_wait_decode && acc.valid && !acc.misaligned);
    assign l15_val = issue & ~hdr_seen_q;

    assign ret_match = (rqtype == lsu_pkg::rq_load  && returntype == lsu_pkg::ret_load) ||
                       (rqtype == lsu_pkg::rq_store && returntype == lsu_pkg::ret_st_ack);
    assign resp_fire = (state_q == st_response) & hdr_seen_q & resp_val & ret_match;
    assign mis_done  = (state_q == st_wait_decode) & acc.valid & acc.misaligned;

    assign req_ack = resp_fire;
    assign done    = resp_fire | mis_done;
    assign busy    = (state_q != st_idle);

    assign ld_misaligned = mis_done & ~acc.mem_op[3];
    assign st_misaligned = mis_done &  acc.mem_op[3];

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle:
                if (strobe) state_d = st_wait_decode;
            st_wait_decode:
                if (acc.valid) begin
                    if (acc.misaligned)
                        state_d = st_idle;          // no request for a bad address
                    else if (header_ack)
                        state_d = st_response;
                    else
                        state_d = st_request;
                end
            st_request:
                if (header_ack) state_d = st_response;
            default:
                if (resp_fire) state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q    <= st_idle;
            hdr_seen_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (done)
                hdr_seen_q <= 1'b0;
            else if (l15_val && header_ack)
                hdr_seen_q <= 1'b1;         // drops val next cycle
        end
    end

endmodule

// File: mem_stage_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mem_stage_top
// memory-access stage of the core, decode through L1.5 cache port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module mem_stage_top (
    input  logic                        clk,
    input  logic                        nrst,
    // core side
    input  logic                        strobe,
    input  lsu_pkg::mem_op_t            mem_op,
    input  logic [lsu_pkg::xlen-1:0]    op_a,
    input  logic [lsu_pkg::xlen-1:0]    op_b,
    input  logic [lsu_pkg::xlen-1:0]    s_imm,
    output logic                        busy,
    output logic                        done,
    output logic [lsu_pkg::xlen-1:0]    load_data,
    output logic                        ld_misaligned,
    output logic                        st_misaligned,
    // cache request
    output logic [3:0]                  l15_rqtype,
    output lsu_pkg::msg_size_t          l15_size,
    output logic [lsu_pkg::xlen-1:0]    l15_address,
    output logic [lsu_pkg::xlen-1:0]    l15_data,
    output logic                        l15_val,
    input  logic                        l15_header_ack,
    // cache response
    input  logic                        l15_resp_val,
    input  logic [3:0]                  l15_returntype,
    input  lsu_pkg::line_word_t         l15_data_0,
    input  lsu_pkg::line_word_t         l15_data_1,
    output logic                        l15_req_ack
);

    lsu_req_if acc ();

    mem_decode u_decode (
        .clk    (clk),
        .nrst   (nrst),
        .strobe (strobe),
        .mem_op (mem_op),
        .op_a   (op_a),
        .op_b   (op_b),
        .s_imm  (s_imm),
        .acc    (acc.decode)
    );

    store_fmt u_store_fmt (
        .acc  (acc.ctrl),
        .data (l15_data),
        .size (l15_size)
    );

    load_align u_load_align (
        .acc       (acc.ctrl),
        .data_0    (l15_data_0),
        .data_1    (l15_data_1),
        .load_data (load_data)
    );

    l15_req_ctrl u_ctrl (
        .clk           (clk),
        .nrst          (nrst),
        .strobe        (strobe),
        .acc           (acc.ctrl),
        .header_ack    (l15_header_ack),
        .resp_val      (l15_resp_val),
        .returntype    (l15_returntype),
        .rqtype        (l15_rqtype),
        .l15_val       (l15_val),
        .req_ack       (l15_req_ack),
        .done          (done),
        .busy          (busy),
        .ld_misaligned (ld_misaligned),
        .st_misaligned (st_misaligned)
    );

    assign l15_address = acc.addr;

endmodule

// File: mem_stage_sva.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mem_stage_sva
// handshake checks on the L1.5 request port of the cache controller
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module mem_stage_sva (
    input  logic        clk,
    input  logic        nrst,
    input  logic        l15_val,
    input  logic        header_ack,
    input  logic        done,
    input  logic [3:0]  rqtype,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  bw
);

    // request held until the header is taken
    a_val_hold: assert property (@(posedge clk) disable iff (!nrst)
        l15_val && !header_ack |=> l15_val)
        else $error("l15_val dropped before header_ack");

    a_fields_stable: assert property (@(posedge clk) disable iff (!nrst)
        l15_val && !header_ack |=> $stable(rqtype) && $stable(addr) && $stable(wdata)
                                   && $stable(bw))
        else $error("request fields changed while l15_val was high");

    // no completion while the header is still outstanding
    a_no_early_done: assert property (@(posedge clk) disable iff (!nrst)
        l15_val && !header_ack |=> !done)
        else $error("done while the request still waited for header_ack");

endmodule

bind l15_req_ctrl mem_stage_sva i_sva (
    .clk        (clk),
    .nrst       (nrst),
    .l15_val    (l15_val),
    .header_ack (header_ack),
    .done       (done),
    .rqtype     (rqtype),
    .addr       (acc.addr),
    .wdata      (acc.wdata),
    .bw         (acc.bw)
);

// File: tb_mem_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_mem_stage
// testbench for the memory-access stage: L1.5 cache model with random
// delays, directed and random loads and stores against a reference model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_mem_stage;

    localparam int n_access    = 254;       // 14 + 28 + 12 + 200
    localparam int cycle_limit = 40 * n_access;

    logic                   clk = 1'b0;
    logic                   nrst;
    logic                   strobe;
    lsu_pkg::mem_op_t       mem_op;
    logic [31:0]            op_a;
    logic [31:0]            op_b;
    logic [31:0]            s_imm;
    logic                   busy;
    logic                   done;
    logic [31:0]            load_data;
    logic                   ld_misaligned;
    logic                   st_misaligned;
    logic [3:0]             l15_rqtype;
    lsu_pkg::msg_size_t     l15_size;
    logic [31:0]            l15_address;
    logic [31:0]            l15_data;
    logic                   l15_val;
    logic                   l15_header_ack;
    logic                   l15_resp_val;
    logic [3:0]             l15_returntype;
    lsu_pkg::line_word_t    l15_data_0;
    lsu_pkg::line_word_t    l15_data_1;
    logic                   l15_req_ack;

    logic [7:0]             cache_mem [0:255];  // memory behind the cache port
    logic [7:0]             shadow_mem [0:255]; // reference copy
    lsu_pkg::mem_op_t       op_table [0:7];
    logic [15:0]            lfsr = 16'd53;
    int                     checks = 0;
    int                     errors = 0;
    int                     cycles = 0;

    // request as seen by the cache model
    logic [31:0]            cap_addr;
    logic [31:0]            cap_data;
    lsu_pkg::msg_size_t     cap_size;
    logic [3:0]             cap_rqtype;
    int                     cap_count = 0;

    mem_stage_top i_dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, an access never completed", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [7:0] fill_byte(input int i);
        return 8'(i * 37 + 11);
    endfunction

    function automatic int op_bytes(input lsu_pkg::mem_op_t op);
        case (op[2:1])
            2'b11:   return 4;
            2'b01:   return 2;
            default: return 1;
        endcase
    endfunction

    // expected result of one access, from the shadow memory
    function automatic void ref_access(
        input  lsu_pkg::mem_op_t    op,
        input  logic [31:0]         addr,
        input  logic [31:0]         sdat,
        output logic [31:0]         ld,
        output logic                mis_ld,
        output logic                mis_st,
        output lsu_pkg::msg_size_t  size,
        output logic [31:0]         swapped
    );
        int         n;
        logic       mis;
        logic [7:0] idx;
        n      = op_bytes(op);
        mis    = (n == 2 && addr[0]) || (n == 4 && addr[1:0] != 2'b00);
        mis_ld = mis & ~op[3];
        mis_st = mis & op[3];
        if (!op[3])
            size = lsu_pkg::size_4b;
        else if (n == 4)
            size = lsu_pkg::size_4b;
        else if (n == 2)
            size = lsu_pkg::size_2b;
        else
            size = lsu_pkg::size_1b;
        swapped = {sdat[7:0], sdat[15:8], sdat[23:16], sdat[31:24]};
        ld = '0;
        for (int k = 0; k < n; k++) begin
            idx            = addr[7:0] + 8'(k);
            ld[8*k +: 8]   = shadow_mem[idx];
        end
        if (op[0] && n == 1)
            ld = {{24{ld[7]}}, ld[7:0]};
        else if (op[0] && n == 2)
            ld = {{16{ld[15]}}, ld[15:0]};
    endfunction

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_size(input lsu_pkg::msg_size_t got, input lsu_pkg::msg_size_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: l15_size is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // one strobe, wait for done, compare everything
    task automatic do_access(input lsu_pkg::mem_op_t op, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] imm);
        logic [31:0]        addr;
        logic [31:0]        exp_ld;
        logic [31:0]        exp_data;
        logic               exp_mis_ld;
        logic               exp_mis_st;
        lsu_pkg::msg_size_t exp_size;
        logic [7:0]         idx;
        logic               val_seen;
        int                 lat;
        int                 reqs0;
        addr = op[3] ? a + imm : a + b;
        ref_access(op, addr, b, exp_ld, exp_mis_ld, exp_mis_st, exp_size, exp_data);
        reqs0 = cap_count;
        @(negedge clk);
        strobe = 1'b1;
        mem_op = op;
        op_a   = a;
        op_b   = b;
        s_imm  = imm;
        @(negedge clk);
        strobe   = 1'b0;
        lat      = 0;
        val_seen = 1'b0;
        do begin
            @(posedge clk);     // sample just before the edge
            lat++;
            check_flag("busy", busy, 1'b1);
            val_seen = val_seen | l15_val;
        end while (!done);
        check_flag("ld_misaligned", ld_misaligned, exp_mis_ld);
        check_flag("st_misaligned", st_misaligned, exp_mis_st);
        check_flag("l15_req_ack", l15_req_ack, !(exp_mis_ld || exp_mis_st));
        if (exp_mis_ld || exp_mis_st) begin
            check_word("done cycle", lat, 2);
            check_flag("l15_val", val_seen, 1'b0);
        end else begin
            check_word("request count", cap_count - reqs0, 1);
            check_word("l15_address", cap_addr, addr);
            check_word("l15_rqtype", {28'b0, cap_rqtype},
                       {28'b0, (op[3] ? lsu_pkg::rq_store : lsu_pkg::rq_load)});
            check_size(cap_size, exp_size);
            if (op[3]) begin
                check_word("l15_data", cap_data, exp_data);
                for (int k = 0; k < op_bytes(op); k++) begin
                    idx             = addr[7:0] + 8'(k);
                    shadow_mem[idx] = b[8*k +: 8];
                end
            end else begin
                check_word("load_data", load_data, exp_ld);
            end
        end
    endtask

    task automatic end_test(input int num, input string name, input int err0);
        $display("test %0d %s: %0d errors", num, name, errors - err0);
    endtask

    // cache model, big-endian lines, random header and response delays
    initial begin : cache_model
        logic [31:0]  d;
        logic [7:0]   base;
        logic [127:0] line;
        int           n;
        l15_header_ack = 1'b0;
        l15_resp_val   = 1'b0;
        l15_returntype = 4'hf;
        l15_data_0     = '0;
        l15_data_1     = '0;
        forever begin
            @(negedge clk);
            if (l15_val) begin
                cap_addr   = l15_address;
                cap_data   = l15_data;
                cap_size   = l15_size;
                cap_rqtype = l15_rqtype;
                cap_count++;
                take_bits(2, d);
                repeat (d[1:0]) @(negedge clk);
                l15_header_ack = 1'b1;
                @(negedge clk);
                l15_header_ack = 1'b0;
                take_bits(2, d);
                repeat (d[1:0]) @(negedge clk);
                if (cap_size == lsu_pkg::size_1b)
                    n = 1;
                else if (cap_size == lsu_pkg::size_2b)
                    n = 2;
                else
                    n = 4;
                if (cap_rqtype == lsu_pkg::rq_store) begin
                    base = cap_addr[7:0];
                    for (int k = 0; k < n; k++)
                        cache_mem[base + 8'(k)] = cap_data[31 - 8*k -: 8];  // first byte on top
                    l15_returntype = lsu_pkg::ret_st_ack;
                end else begin
                    base = {cap_addr[7:4], 4'b0000};
                    for (int k = 0; k < 16; k++)
                        line[127 - 8*k -: 8] = cache_mem[base + 8'(k)];
                    {l15_data_0, l15_data_1} = line;
                    l15_returntype = lsu_pkg::ret_load;
                end
                l15_resp_val = 1'b1;
                @(negedge clk);
                l15_resp_val   = 1'b0;
                l15_returntype = 4'hf;
                l15_data_0     = '0;
                l15_data_1     = '0;
            end
        end
    end

    initial begin
        int                 err0;
        logic [31:0]        ra;
        logic [31:0]        rb;
        logic [31:0]        ri;
        lsu_pkg::mem_op_t   op;
        nrst   = 1'b0;
        strobe = 1'b0;
        mem_op = lsu_pkg::op_none;
        op_a   = '0;
        op_b   = '0;
        s_imm  = '0;
        op_table = '{lsu_pkg::op_sw, lsu_pkg::op_sh, lsu_pkg::op_sb, lsu_pkg::op_lw,
                     lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_lb, lsu_pkg::op_lbu};
        for (int i = 0; i < 256; i++) begin
            cache_mem[i]  = fill_byte(i);
            shadow_mem[i] = fill_byte(i);
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;

        err0 = errors;
        @(negedge clk);
        check_flag("l15_val", l15_val, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("busy", busy, 1'b0);
        end_test(1, "reset state", err0);

        err0 = errors;
        for (int off = 0; off < 4; off++) begin
            do_access(lsu_pkg::op_sb, 32'h40, 32'h8a5c_f3e1 + off, off);
            do_access(lsu_pkg::op_lbu, 32'h40, off, 0);
        end
        for (int off = 0; off < 4; off += 2) begin
            do_access(lsu_pkg::op_sh, 32'h48, 32'h3c96_e70d + off, off);
            do_access(lsu_pkg::op_lhu, 32'h48, off, 0);
        end
        do_access(lsu_pkg::op_sw, 32'h50, 32'hc0de_5a17, 0);
        do_access(lsu_pkg::op_lw, 32'h50, 0, 0);
        end_test(2, "aligned stores and read-back", err0);

        err0 = errors;
        do_access(lsu_pkg::op_sw, 32'h80, 32'h8f7f_80e0, 0);    // negative bytes and halves
        do_access(lsu_pkg::op_sw, 32'h80, 32'h7f01_7ffe, 4);
        for (int w = 0; w < 8; w += 4) begin
            for (int off = 0; off < 4; off++) begin
                do_access(lsu_pkg::op_lb, 32'h80, w + off, 0);
                do_access(lsu_pkg::op_lbu, 32'h80, w + off, 0);
            end
            for (int off = 0; off < 4; off += 2) begin
                do_access(lsu_pkg::op_lh, 32'h80, w + off, 0);
                do_access(lsu_pkg::op_lhu, 32'h80, w + off, 0);
            end
            do_access(lsu_pkg::op_lw, 32'h80, w, 0);
        end
        end_test(3, "load extension", err0);

        err0 = errors;
        for (int off = 1; off < 4; off += 2) begin
            do_access(lsu_pkg::op_lh, 32'h90, off, 0);
            do_access(lsu_pkg::op_lhu, 32'h90, off, 0);
            do_access(lsu_pkg::op_sh, 32'h90, 32'h1234_5678, off);
        end
        for (int off = 1; off < 4; off++) begin
            do_access(lsu_pkg::op_lw, 32'h90, off, 0);
            do_access(lsu_pkg::op_sw, 32'h90, 32'h9abc_def0, off);
        end
        end_test(4, "misaligned accesses", err0);

        err0 = errors;
        repeat (200) begin
            take_bits(3, ra);
            op = op_table[ra[2:0]];
            take_bits(8, ra);
            take_bits(32, rb);
            take_bits(4, ri);
            if (op[3])
                do_access(op, {24'b0, ra[7:0]}, rb, {28'b0, ri[3:0]});
            else
                do_access(op, {24'b0, ra[7:0]}, {28'b0, rb[3:0]}, {28'b0, ri[3:0]});
        end
        end_test(5, "random operations", err0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: mem_stage_top.f
lsu_pkg.sv
lsu_req_if.sv
mem_decode.sv
store_fmt.sv
load_align.sv
l15_req_ctrl.sv
mem_stage_top.sv
mem_stage_sva.sv
tb_mem_stage.sv

// File: Makefile
# Verilator build and run of the memory-access stage testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_mem_stage -f mem_stage_top.f -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
